// ==== sim.f ====
+incdir+common
common/scope_pkg.sv
common/cmd_if.sv
common/acq_status_if.sv
rtl/cmd_decode.sv
acq/trigger_acq.sv
rtl/reply_tx.sv
rtl/scope_ctrl_top.sv
tests/tb_scope_ctrl.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the controller testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_scope_ctrl -o tb_scope_ctrl

./obj_dir/tb_scope_ctrl | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== tests/tb_scope_ctrl.sv ====
`timescale 1ns/1ps
// Testbench of the digitizer controller.
// Runs a command table, then immediate and threshold triggers, readout and downsample.

module tb_scope_ctrl;

	logic clk = 1'b0;
	logic rstn;
	logic i_rx_valid, o_rx_ready, i_tx_ready, o_ram_wr, o_tx_valid, o_tx_last;
	scope_pkg::byte_t     i_rx_data, i_board;
	scope_pkg::sample_t   i_sample;
	logic [3:0]           i_overrange, o_tx_keep;
	scope_pkg::ram_addr_t o_ram_wr_address;
	scope_pkg::word_t     o_tx_data;

	int unsigned rng_state = 65959;
	int          mismatches = 0;
	int          timeouts = 0;
	int          stb_addr;     // write address seen while the strobe is high
	int          ev_exp = 0;   // event count the host should see
	int          ovr_held = 0; // clocks overrange input 1 was held high

	int          ramp [11] = '{0, -32, -64, -96, -64, -16, 32, 80, 112, 144, 176};
	int          ds_list [3] = '{0, 2, 3};

	// command table: bytes, expected reply, mode (0 value, 1 no reply, 2 overrange count), stall
	logic [63:0] tbl_cmd [7];
	logic [31:0] tbl_exp [7];
	int          tbl_mode [7];
	int          tbl_stall [7];

	scope_ctrl_top scope_ctrl_top_inst (.*);

	always #10 clk = ~clk;

	function automatic int unsigned lcg_next();
		rng_state = rng_state * 1103515245 + 12345;
		return rng_state >> 16;
	endfunction

	function automatic logic [63:0] cmd8(input logic [7:0] op, b1, b2, b3, b4, b5);
		return {16'd0, b5, b4, b3, b2, b1, op};
	endfunction

	task automatic set_row(input int idx, input logic [63:0] c, input logic [31:0] exp,
	                       input int mode);
		tbl_cmd[idx]   = c;
		tbl_exp[idx]   = exp;
		tbl_mode[idx]  = mode;
		tbl_stall[idx] = idx; // back-pressure grows down the table
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	// ----------------------------------------------------------
	// host side of the byte and word streams
	// ----------------------------------------------------------
	task automatic send_cmd(input logic [63:0] c);
		int n;
		for (int i = 0; i < 8; i++) begin
			n = 0;
			while (!o_rx_ready && n < 50) begin
				@(negedge clk);
				n++;
			end
			if (!o_rx_ready) begin
				$display("timeout: rx_ready stayed low at byte %0d, t=%0t", i, $time);
				timeouts++;
			end
			i_rx_valid = 1'b1;
			i_rx_data  = c[8*i +: 8];
			i_sample   = scope_pkg::sample_t'(int'(lcg_next() % 61) - 30); // quiet noise
			@(negedge clk);
		end
		i_rx_valid = 1'b0;
		stb_addr   = int'(o_ram_wr_address);
	endtask

	task automatic run_cmd(input logic [63:0] c, input int stall, input bit expect_reply,
	                       output logic [31:0] w);
		int n;
		send_cmd(c);
		n = 1;
		w = 'x;
		while (!o_tx_valid && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!o_tx_valid) begin
			if (expect_reply) begin
				$display("timeout: no reply to opcode %0d, t=%0t", c[7:0], $time);
				timeouts++;
			end
			return;
		end
		if (!expect_reply) begin
			$display("unexpected reply to unknown opcode %0d, t=%0t", c[7:0], $time);
			mismatches++;
		end
		check_val("reply_latency", n, 2);
		for (int s = 0; s < stall; s++) begin
			check_val("o_tx_valid", o_tx_valid, 1);
			check_val("o_tx_keep", o_tx_keep, 4'hf);
			check_val("o_tx_last", o_tx_last, 1);
			@(negedge clk);
		end
		w = o_tx_data;
		i_tx_ready = 1'b1;
		@(negedge clk);
		i_tx_ready = 1'b0;
		check_val("o_tx_valid", o_tx_valid, 0);
	endtask

	task automatic wait_ram_wr(input logic level, output int cycles);
		cycles = 0;
		while (o_ram_wr !== level && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		if (o_ram_wr !== level) begin
			$display("timeout: o_ram_wr never went to %0b, t=%0t", level, $time);
			timeouts++;
		end
	endtask

	initial begin
		logic [31:0] w;
		int          n, prev, trig, above, done_cycles;

		rstn = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data = '0;
		i_tx_ready = 1'b0;
		i_sample = '0;
		i_board = 8'h5a;
		i_overrange = 4'b0000;
		set_row(0, cmd8(2, 0, 0, 0, 0, 0), 17, 0);
		set_row(1, cmd8(2, 1, 0, 0, 0, 0), 32'h5a5a5a5a, 0);
		set_row(2, cmd8(5, 1, 2, 3, 4, 5), 0, 1);
		set_row(3, cmd8(2, 2, 1, 0, 0, 0), 0, 2);
		set_row(4, cmd8(8, 128, 4, 1, 8'h20, 3), 8, 0);
		set_row(5, cmd8(9, 0, 0, 0, 0, 0), 9, 0);
		set_row(6, cmd8(2, 3, 0, 0, 0, 0), 32'h1, 0); // idle flag only

		repeat (8) @(negedge clk);
		rstn = 1'b1;
		check_val("o_rx_ready", o_rx_ready, 1);
		check_val("o_tx_valid", o_tx_valid, 0);
		i_overrange = 4'b0010; // input 1 overranged for 37 clocks
		for (int cyc = 0; cyc < 37; cyc++) begin
			@(negedge clk);
			ovr_held++;
		end
		i_overrange = 4'b0000;

		// ----------------------------------------------------------
		// table of info and settings commands
		// ----------------------------------------------------------
		for (int i = 0; i < 7; i++) begin
			run_cmd(tbl_cmd[i], tbl_stall[i] + int'(lcg_next() % 4), tbl_mode[i] != 1, w);
			if (tbl_mode[i] != 1) begin
				check_val($sformatf("o_tx_data[row %0d]", i), w,
				          (tbl_mode[i] == 2) ? 32'(ovr_held) : tbl_exp[i]);
			end
		end

		// immediate trigger, length 6
		run_cmd(cmd8(1, 0, 0, 0, 6, 0), 1, 1, w);
		check_val("o_tx_data[arm]", w, {16'(ev_exp), 16'h0});
		trig = stb_addr;
		n = 0;
		do begin
			run_cmd(cmd8(1, 0, 0, 0, 6, 0), int'(lcg_next() % 3), 1, w);
			n++;
		end while (w[15:0] !== 16'hffff && n < 40);
		if (w[15:0] !== 16'hffff) begin
			$display("timeout: immediate trigger event never completed, t=%0t", $time);
			timeouts++;
		end
		ev_exp++;
		check_val("event_count", w[31:16], ev_exp);
		check_val("o_ram_wr", o_ram_wr, 0);
		run_cmd(cmd8(2, 3, 0, 0, 0, 0), 1, 1, w);
		check_val("o_tx_data[flags]", w, 32'h2); // done, not idle
		run_cmd(cmd8(0, 0, 0, 0, 0, 0), 2, 1, w);
		check_val("o_tx_data[readout]", w, (trig - 288) & 1023);
		wait_ram_wr(1'b1, n);

		// ----------------------------------------------------------
		// falling threshold trigger, lower -56, upper 72, tot 3
		// ----------------------------------------------------------
		run_cmd(cmd8(1, 1, 0, 0, 4, 0), 0, 1, w);
		check_val("o_tx_data[arm]", w, {16'(ev_exp), 16'h0});
		run_cmd(cmd8(1, 1, 0, 0, 4, 0), 1, 1, w);
		check_val("o_tx_data[poll]", w, {16'(ev_exp), 16'h0});
		above = 0;
		for (int i = 0; i < 11; i++) begin
			i_sample = scope_pkg::sample_t'(ramp[i]);
			if (ramp[i] > 72) begin
				above++;
			end
			@(negedge clk);
			if (above == 4 && ramp[i] > 72) begin
				trig = int'(o_ram_wr_address); // FSM sees this sample on the next edge
				break;
			end
			check_val("o_ram_wr", o_ram_wr, 1);
		end
		i_sample = 12'sd200;
		wait_ram_wr(1'b0, done_cycles);
		if (done_cycles < 4) begin
			$display("event finished after %0d clocks, earlier than its length", done_cycles);
			mismatches++;
		end
		run_cmd(cmd8(1, 1, 0, 0, 4, 0), 0, 1, w);
		ev_exp++;
		check_val("o_tx_data[poll]", w, {16'(ev_exp), 16'hffff});
		run_cmd(cmd8(0, 0, 0, 0, 0, 0), 3, 1, w);
		check_val("o_tx_data[readout]", w, (trig - 288) & 1023);
		wait_ram_wr(1'b1, n);

		// ----------------------------------------------------------
		// downsample step measured while idle
		// ----------------------------------------------------------
		foreach (ds_list[k]) begin
			run_cmd(cmd8(9, 8'(ds_list[k]), 0, 0, 0, 0), 1, 1, w);
			check_val("o_tx_data[downsample]", w, 9);
			for (int pass = 0; pass < 2; pass++) begin
				prev = int'(o_ram_wr_address);
				n = 0;
				while (int'(o_ram_wr_address) == prev && n < 40) begin
					@(negedge clk);
					n++;
				end
				if (int'(o_ram_wr_address) == prev) begin
					$display("timeout: write address stuck at downsample %0d", ds_list[k]);
					timeouts++;
				end
			end
			check_val("address_step_clocks", n, 1 << ds_list[k]);
		end

		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/scope_ctrl_top.sv ====
`timescale 1ns/1ps
// Digitizer command and trigger controller, top level.
// Host byte stream in, reply word stream out, sample RAM write control.

module scope_ctrl_top (
	input  logic                 clk,
	input  logic                 rstn,
	// host byte stream
	input  logic                 i_rx_valid,
	input  scope_pkg::byte_t     i_rx_data,
	output logic                 o_rx_ready,
	// ADC and board inputs
	input  scope_pkg::sample_t   i_sample,
	input  scope_pkg::byte_t     i_board,
	input  logic [3:0]           i_overrange,
	// sample RAM write port
	output logic                 o_ram_wr,
	output scope_pkg::ram_addr_t o_ram_wr_address,
	// reply word stream
	output logic                 o_tx_valid,
	output scope_pkg::word_t     o_tx_data,
	output logic [3:0]           o_tx_keep,
	output logic                 o_tx_last,
	input  logic                 i_tx_ready
);

	cmd_if        cmd_bus ();
	acq_status_if acq_bus ();

	// ----------------------------------------------------------
	// command decode, acquisition, reply
	// ----------------------------------------------------------
	cmd_decode cmd_decode_inst (
		.clk        (clk),
		.rstn       (rstn),
		.i_rx_valid (i_rx_valid),
		.i_rx_data  (i_rx_data),
		.o_rx_ready (o_rx_ready),
		.cmd        (cmd_bus.decoder)
	);

	trigger_acq trigger_acq_inst (
		.clk              (clk),
		.rstn             (rstn),
		.i_sample         (i_sample),
		.o_ram_wr         (o_ram_wr),
		.o_ram_wr_address (o_ram_wr_address),
		.cmd              (cmd_bus.acq),
		.stat             (acq_bus.source)
	);

	reply_tx reply_tx_inst (
		.clk         (clk),
		.rstn        (rstn),
		.i_board     (i_board),
		.i_overrange (i_overrange),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data),
		.o_tx_keep   (o_tx_keep),
		.o_tx_last   (o_tx_last),
		.i_tx_ready  (i_tx_ready),
		.cmd         (cmd_bus.reply),
		.stat        (acq_bus.sink)
	);

endmodule

// ==== rtl/reply_tx.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"
// Reply builder.
// Selects one 32-bit reply word per command and holds it on the word stream until taken.

module reply_tx (
	input  logic             clk,
	input  logic             rstn,
	input  scope_pkg::byte_t i_board,
	input  logic [3:0]       i_overrange,
	output logic             o_tx_valid,
	output scope_pkg::word_t o_tx_data,
	output logic [3:0]       o_tx_keep,
	output logic             o_tx_last,
	input  logic             i_tx_ready,
	cmd_if.reply             cmd,
	acq_status_if.sink       stat
);

	scope_pkg::word_t ovr_count [4]; // clocks spent in overrange, per ADC input
	scope_pkg::word_t reply_word;

	// ----------------------------------------------------------
	// overrange counters
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < 4; i++) begin
				ovr_count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (i_overrange[i]) begin
					ovr_count[i] <= ovr_count[i] + 32'd1;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// reply selection
	// ----------------------------------------------------------
	always_comb begin
		reply_word = '0;
		case (cmd.opcode)
			`OP_READOUT: reply_word = 32'(stat.read_start);
			`OP_ARM:     reply_word = {stat.event_count, stat.post_count}; // status before arm
			`OP_INFO: begin
				case (cmd.args[1])
					8'd0: reply_word = 32'(`SCOPE_VERSION);
					8'd1: reply_word = {i_board, i_board, i_board, i_board};
					8'd2: reply_word = ovr_count[cmd.args[2][1:0]];
					8'd3: reply_word = {30'd0, stat.done, stat.idle}; // acquisition flags
					default: reply_word = '0;
				endcase
			end
			`OP_TRIG_SET:   reply_word = 32'(`OP_TRIG_SET);   // settings echo the opcode
			`OP_DOWNSAMPLE: reply_word = 32'(`OP_DOWNSAMPLE);
			default:        reply_word = '0;
		endcase
	end

	// ----------------------------------------------------------
	// word stream
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tx_valid <= 1'b0;
		end else if (cmd.cmd_stb) begin
			o_tx_valid <= 1'b1;
		end else if (i_tx_ready) begin
			o_tx_valid <= 1'b0; // word taken
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.cmd_stb) begin
			o_tx_data <= reply_word;
		end
	end

	assign cmd.reply_done = o_tx_valid && i_tx_ready;

	// every reply is a single full word
	assign o_tx_keep = 4'b1111;
	assign o_tx_last = 1'b1;

endmodule

// ==== acq/trigger_acq.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"
// Trigger and acquisition engine.
// Steps the circular RAM write address, detects threshold triggers with a
// time-over-threshold count and takes the post-trigger writes of each event.

module trigger_acq (
	input  logic                 clk,
	input  logic                 rstn,
	input  scope_pkg::sample_t   i_sample,
	output logic                 o_ram_wr,
	output scope_pkg::ram_addr_t o_ram_wr_address,
	cmd_if.acq                   cmd,
	acq_status_if.source         stat
);

	// settings
	scope_pkg::sample_t    lower_thresh;
	scope_pkg::sample_t    upper_thresh;
	scope_pkg::ram_addr_t  preoffset;
	scope_pkg::byte_t      tot;
	scope_pkg::count16_t   take_len;
	logic [4:0]            downsample;

	// acquisition
	scope_pkg::acq_state_t state;
	scope_pkg::sample_t    sample_q;
	logic [31:0]           ds_count;
	logic                  ds_tick;
	scope_pkg::ram_addr_t  trig_addr;
	scope_pkg::byte_t      tot_count;
	scope_pkg::count16_t   post_count;
	scope_pkg::count16_t   event_count;

	// command decode
	logic                  set_trig;
	logic                  set_arm;
	logic                  set_ds;
	logic                  release_evt;
	logic [11:0]           code_lo;
	logic [11:0]           code_hi;

	assign set_trig    = cmd.cmd_stb && (cmd.opcode == `OP_TRIG_SET);
	assign set_arm     = cmd.cmd_stb && (cmd.opcode == `OP_ARM);
	assign set_ds      = cmd.cmd_stb && (cmd.opcode == `OP_DOWNSAMPLE);
	assign release_evt = cmd.cmd_stb && (cmd.opcode == `OP_READOUT);

	// centre code and window half-width, wraps at 12 bits
	assign code_lo = {4'd0, cmd.args[1]} - {4'd0, cmd.args[2]} - 12'(`THRESH_CENTER);
	assign code_hi = {4'd0, cmd.args[1]} + {4'd0, cmd.args[2]} - 12'(`THRESH_CENTER);

	// ----------------------------------------------------------
	// settings registers
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lower_thresh <= '0;
			upper_thresh <= '0;
			preoffset    <= '0;
			tot          <= '0;
			take_len     <= '0;
			downsample   <= '0;
		end else begin
			if (set_trig) begin
				lower_thresh <= scope_pkg::sample_t'((code_lo << `THRESH_SHIFT)
				                + 12'(`THRESH_ROUND));
				upper_thresh <= scope_pkg::sample_t'((code_hi << `THRESH_SHIFT)
				                + 12'(`THRESH_ROUND));
				preoffset    <= {cmd.args[3][1:0], cmd.args[4]};
				tot          <= cmd.args[5];
			end
			if (set_arm) begin
				take_len <= {cmd.args[5], cmd.args[4]};
			end
			if (set_ds) begin
				downsample <= cmd.args[1][4:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		sample_q <= i_sample;
	end

	// ----------------------------------------------------------
	// RAM write addressing
	// ----------------------------------------------------------
	assign ds_tick = ds_count[downsample]; // counter starts at 1, so 2^d clocks per step

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_ram_wr         <= 1'b0;
			o_ram_wr_address <= '0;
			ds_count         <= 32'd1;
		end else if (state != scope_pkg::ACQ_DONE) begin
			o_ram_wr <= 1'b1; // keep writing so the pretrigger history is there
			if (ds_tick) begin
				ds_count         <= 32'd1;
				o_ram_wr_address <= o_ram_wr_address + 1'b1;
			end else begin
				ds_count <= ds_count + 32'd1;
			end
		end else begin
			o_ram_wr <= 1'b0; // hold the event for readout
			ds_count <= 32'd1;
		end
	end

	// ----------------------------------------------------------
	// trigger FSM and event counting
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= scope_pkg::ACQ_IDLE;
			trig_addr   <= '0;
			tot_count   <= '0;
			post_count  <= '0;
			event_count <= '0;
		end else begin
			case (state)
				scope_pkg::ACQ_IDLE: begin
					tot_count <= '0;
					if (set_arm) begin
						case (cmd.args[1])
							8'd1: state <= scope_pkg::ACQ_WAIT_FIRST_FALL;
							8'd2: state <= scope_pkg::ACQ_WAIT_FIRST_RISE;
							default: begin
								trig_addr <= o_ram_wr_address; // immediate trigger
								state     <= scope_pkg::ACQ_POST;
							end
						endcase
					end
				end
				scope_pkg::ACQ_WAIT_FIRST_FALL: begin
					if (sample_q < lower_thresh) begin
						state <= scope_pkg::ACQ_WAIT_SECOND_FALL;
					end
				end
				scope_pkg::ACQ_WAIT_SECOND_FALL: begin
					if (sample_q > upper_thresh) begin
						tot_count <= tot_count + 8'd1;
						if (tot_count >= tot) begin
							trig_addr <= o_ram_wr_address;
							state     <= scope_pkg::ACQ_POST;
						end
					end
				end
				scope_pkg::ACQ_WAIT_FIRST_RISE: begin
					if (sample_q > upper_thresh) begin
						state <= scope_pkg::ACQ_WAIT_SECOND_RISE;
					end
				end
				scope_pkg::ACQ_WAIT_SECOND_RISE: begin
					if (sample_q < lower_thresh) begin
						tot_count <= tot_count + 8'd1;
						if (tot_count >= tot) begin
							trig_addr <= o_ram_wr_address;
							state     <= scope_pkg::ACQ_POST;
						end
					end
				end
				scope_pkg::ACQ_POST: begin
					if (post_count < take_len) begin
						if (ds_tick) begin
							post_count <= post_count + 16'd1; // one per address step
						end
					end else begin
						event_count <= event_count + 16'd1;
						post_count  <= '1; // host polls for all ones
						state       <= scope_pkg::ACQ_DONE;
					end
				end
				scope_pkg::ACQ_DONE: begin
					if (release_evt) begin
						post_count <= '0;
						state      <= scope_pkg::ACQ_IDLE;
					end
				end
				default: state <= scope_pkg::ACQ_IDLE;
			endcase
		end
	end

	assign stat.idle        = (state == scope_pkg::ACQ_IDLE);
	assign stat.done        = (state == scope_pkg::ACQ_DONE);
	assign stat.event_count = event_count;
	assign stat.post_count  = post_count;
	assign stat.read_start  = trig_addr - preoffset; // wraps around the circular RAM

endmodule

// ==== rtl/cmd_decode.sv ====
`timescale 1ns/1ps
`include "scope_cfg.svh"
// Host command collector.
// Gathers 8-byte commands, strobes the known ones and holds off until the reply is sent.

module cmd_decode (
	input  logic             clk,
	input  logic             rstn,
	input  logic             i_rx_valid,
	input  scope_pkg::byte_t i_rx_data,
	output logic             o_rx_ready,
	cmd_if.decoder           cmd
);

	scope_pkg::byte_t rx_buf [0:`CMD_BYTES-1]; // bytes of the command being collected
	logic [2:0]       rx_count;
	logic             rx_fire;
	logic             last_byte;
	logic             op_known;
	logic             wait_reply;

	assign rx_fire   = i_rx_valid && o_rx_ready;
	assign last_byte = (rx_count == 3'(`CMD_BYTES - 1));

	// opcode byte was stored with the first transfer
	assign op_known = (rx_buf[0] == `OP_READOUT)  ||
	                  (rx_buf[0] == `OP_ARM)      ||
	                  (rx_buf[0] == `OP_INFO)     ||
	                  (rx_buf[0] == `OP_TRIG_SET) ||
	                  (rx_buf[0] == `OP_DOWNSAMPLE);

	// ----------------------------------------------------------
	// byte counting and flow control
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rx_count    <= '0;
			o_rx_ready  <= 1'b1;
			wait_reply  <= 1'b0;
			cmd.cmd_stb <= 1'b0;
		end else begin
			cmd.cmd_stb <= 1'b0;
			if (rx_fire) begin
				if (last_byte) begin
					rx_count    <= '0;
					o_rx_ready  <= 1'b0;
					wait_reply  <= op_known; // unknown commands get no reply
					cmd.cmd_stb <= op_known;
				end else begin
					rx_count <= rx_count + 3'd1;
				end
			end else if (!o_rx_ready) begin
				if (!wait_reply) begin
					o_rx_ready <= 1'b1; // dropped command, resume collecting
				end else if (cmd.reply_done) begin
					o_rx_ready <= 1'b1;
					wait_reply <= 1'b0;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// command payload
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rx_fire) begin
			rx_buf[rx_count] <= i_rx_data;
		end
		if (rx_fire && last_byte) begin
			cmd.opcode <= rx_buf[0];
			cmd.args   <= {i_rx_data, rx_buf[6], rx_buf[5], rx_buf[4],
			               rx_buf[3], rx_buf[2], rx_buf[1]}; // last byte arrives live
		end
	end

endmodule

// ==== common/acq_status_if.sv ====
`timescale 1ns/1ps
// Acquisition status from the trigger engine to the reply builder.

interface acq_status_if;

	logic                 idle;        // armed acquisition may start
	logic                 done;        // event held, RAM writes stopped
	scope_pkg::count16_t  event_count;
	scope_pkg::count16_t  post_count;  // 0 in idle, all ones in done
	scope_pkg::ram_addr_t read_start;  // trigger address minus pretrigger

	modport source (
		output idle,
		output done,
		output event_count,
		output post_count,
		output read_start
	);

	modport sink (
		input idle,
		input done,
		input event_count,
		input post_count,
		input read_start
	);

endinterface

// ==== common/cmd_if.sv ====
`timescale 1ns/1ps
// Decoded host command.
// The decoder strobes one known command, acquisition and reply act on it.

interface cmd_if;

	logic                   cmd_stb;    // one cycle per known command
	scope_pkg::opcode_t     opcode;
	scope_pkg::byte_t [7:1] args;       // bytes 1 to 7, stable until next strobe
	logic                   reply_done; // reply word accepted by the host

	modport decoder (
		output cmd_stb,
		output opcode,
		output args,
		input  reply_done
	);

	modport acq (
		input cmd_stb,
		input opcode,
		input args
	);

	modport reply (
		input  cmd_stb,
		input  opcode,
		input  args,
		output reply_done
	);

endinterface

// ==== common/scope_pkg.sv ====
// Shared types of the digitizer controller.
// Widths follow the host protocol and the ADC, the RAM width comes from the cfg header.

`include "scope_cfg.svh"

package scope_pkg;

	typedef logic [7:0] byte_t; // stream byte or command argument

	typedef logic signed [11:0] sample_t; // ADC sample or threshold

	typedef logic [`SCOPE_RAM_AW-1:0] ram_addr_t;

	typedef logic [15:0] count16_t; // event, post-trigger and length counts

	typedef logic [31:0] word_t; // one reply word

	typedef logic [7:0] opcode_t;

	// ----------------------------------------------------------
	// acquisition state machine
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		ACQ_IDLE,             // writing, waiting for arm
		ACQ_WAIT_FIRST_FALL,  // falling trigger, waiting to go below lower
		ACQ_WAIT_SECOND_FALL, // falling trigger, counting samples above upper
		ACQ_WAIT_FIRST_RISE,  // rising trigger, waiting to go above upper
		ACQ_WAIT_SECOND_RISE, // rising trigger, counting samples below lower
		ACQ_POST,             // triggered, taking post-trigger writes
		ACQ_DONE              // event held in RAM, writes stopped
	} acq_state_t;

endpackage

// ==== common/scope_cfg.svh ====
// Configuration constants of the digitizer command and trigger controller.
// Covers the host protocol opcodes, the sample RAM geometry and the threshold coding.

`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

`define SCOPE_VERSION 17 // reported by opcode 2, selector 0

`define SCOPE_RAM_AW 10 // circular sample RAM, 1024 entries

// ----------------------------------------------------------
// host command opcodes
// ----------------------------------------------------------
`define OP_READOUT    8'd0 // read-start address, event release
`define OP_ARM        8'd1 // trigger type and length, arm, status
`define OP_INFO       8'd2 // version, board input, overrange
`define OP_TRIG_SET   8'd8 // thresholds, pretrigger, time over threshold
`define OP_DOWNSAMPLE 8'd9 // downsample step

// ----------------------------------------------------------
// threshold code to sample value mapping
// ----------------------------------------------------------
`define THRESH_CENTER 128 // host code for a zero sample
`define THRESH_SHIFT  4   // one code step is 16 ADC counts
`define THRESH_ROUND  8   // half a step, lands in the middle

`define CMD_BYTES 8 // opcode plus seven argument bytes

`endif
